// File: project.f
+incdir+.
pong_pkg.sv
game_tick.sv
paddle_ctrl.sv
ball_engine.sv
score_keeper.sv
frame_render.sv
seg_display.sv
pong_top.sv
tb_pong_asserts.sv
tb_pong.sv

// File: run.sh
#!/bin/bash
# build and run with Verilator, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tb_pong -o sim_pong \
	> build.log 2>&1 \
	&& ./obj_dir/sim_pong > sim.log 2>&1 \
	|| echo "Simulation failed" >> sim.log
cat sim.log
! grep -q "Simulation failed" sim.log

// File: tb_pong_model.svh
// ------------------------------------------------------------
// reference game model living in the tb_pong scope
// ------------------------------------------------------------
int m_pad[4] = '{int'(pong_pkg::VPADDLE_START), int'(pong_pkg::VPADDLE_START),
	int'(pong_pkg::HPADDLE_START), int'(pong_pkg::HPADDLE_START)}; // left, right, top, bottom
int m_bx[2] = '{int'(pong_pkg::BALL_START_X), int'(pong_pkg::BALL_START_X)};
int m_by[2] = '{int'(pong_pkg::BALL_START_Y), int'(pong_pkg::BALL_START_Y)};
int m_dx[2] = '{1, 1};    // +1 right
int m_dy[2] = '{-1, -1};  // -1 up
int m_score = 0;
int m_lives = int'(pong_pkg::LIVES_START);
int m_hits = 0;           // pulses waiting for the score edge
int m_losts = 0;
int scan_x = 0;
int scan_y = 0;

function automatic bit level2_on();
	return m_score >= int'(pong_pkg::LEVEL2_SCORE);
endfunction

function automatic bit on_pad(input int i, input int v);
	return v >= m_pad[i] && v <= m_pad[i] + int'(pong_pkg::PADDLE_LEN);
endfunction

function automatic bit in_draw(input int i, input int v);
	return m_pad[i] < v && v < m_pad[i] + int'(pong_pkg::PADDLE_LEN); // edges stay dark
endfunction

function automatic int pad_move(input int pos, input bit dec, input int lo, input int hi);
	if (dec && pos >= lo)
		return pos - int'(pong_pkg::PADDLE_STEP);
	if (!dec && pos <= hi)
		return pos + int'(pong_pkg::PADDLE_STEP);
	return pos;
endfunction

// bounce off paddle i at its hit line or flag the ball lost past lim
task automatic wall(inout int pos, inout int dir, input int other, input int i,
	input int line, input int lim, input int away, inout bit hit, inout bit lost);
	if (pos == line && on_pad(i, other))
	begin
		dir = away;
		pos = pos + away * int'(pong_pkg::BOUNCE_KICK);
		hit = 1'b1;
	end
	else if ((away > 0) ? pos <= lim : pos >= lim)
		lost = 1'b1;
endtask

task automatic ball_step(input int b);
	int x;
	int y;
	bit hit;
	bit lost;
	x = m_bx[b] + m_dx[b];
	y = m_by[b] + m_dy[b];
	hit = 1'b0;
	lost = 1'b0;
	wall(x, m_dx[b], y, 0, int'(pong_pkg::HIT_LEFT_X), int'(pong_pkg::LOST_LEFT_X), 1,
		hit, lost);
	wall(x, m_dx[b], y, 1, int'(pong_pkg::HIT_RIGHT_X), int'(pong_pkg::LOST_RIGHT_X), -1,
		hit, lost);
	wall(y, m_dy[b], x, 2, int'(pong_pkg::HIT_TOP_Y), int'(pong_pkg::LOST_TOP_Y), 1,
		hit, lost); // sees x after any side kick
	wall(y, m_dy[b], x, 3, int'(pong_pkg::HIT_BOTTOM_Y), int'(pong_pkg::LOST_BOTTOM_Y), -1,
		hit, lost);
	m_hits += int'(hit);
	m_losts += int'(lost);
	m_bx[b] = lost ? int'(pong_pkg::BALL_START_X) : x;
	m_by[b] = lost ? int'(pong_pkg::BALL_START_Y) : y;
endtask

// paddles move after the balls have used the old positions
task automatic model_tick();
	ball_step(0);
	if (level2_on())
		ball_step(1);
	m_pad[0] = pad_move(m_pad[0], sw_left, int'(pong_pkg::VPADDLE_MIN),
		int'(pong_pkg::VPADDLE_MAX));
	m_pad[1] = pad_move(m_pad[1], sw_right, int'(pong_pkg::VPADDLE_MIN),
		int'(pong_pkg::VPADDLE_MAX));
	m_pad[2] = pad_move(m_pad[2], !sw_top, int'(pong_pkg::HPADDLE_MIN),
		int'(pong_pkg::HPADDLE_MAX));
	m_pad[3] = pad_move(m_pad[3], !sw_bottom, int'(pong_pkg::HPADDLE_MIN),
		int'(pong_pkg::HPADDLE_MAX));
endtask

task automatic model_score();
	if (m_lives > 0)
		m_score += m_hits * int'(pong_pkg::POINTS_PER_HIT);
	m_lives = (m_lives > m_losts) ? m_lives - m_losts : 0;
	score_evt = m_hits > 0;
	loss_evt = m_losts > 0;
	m_hits = 0;
	m_losts = 0;
endtask

task automatic model_scan();
	if (scan_y == pong_pkg::SCREEN_H - 1)
	begin
		scan_y = 0;
		scan_x = (scan_x == pong_pkg::SCREEN_W - 1) ? 0 : scan_x + 1;
	end
	else
		scan_y++;
endtask

// switch value for paddle i that follows ball 0
function automatic bit steer(input int i);
	int ball;
	bit past;
	ball = (i < 2) ? m_by[0] : m_bx[0];
	past = m_pad[i] + int'(pong_pkg::PADDLE_LEN) / 2 > ball; // centre beyond the ball
	case (steer_mode)
		1: return (i < 2) ? ball > int'(pong_pkg::BALL_START_Y)
			: ball < int'(pong_pkg::BALL_START_X); // park on the far side
		2: return (i < 2) ? past : !past;
		default: return 1'b0;
	endcase
endfunction

function automatic pong_pkg::colour_t exp_colour(input int x, input int y);
	bit white;
	white = (x == m_bx[0] && y == m_by[0]) || (level2_on() && x == m_bx[1] && y == m_by[1]);
	white = white || (x <= int'(pong_pkg::DRAW_LEFT_X_MAX) && in_draw(0, y))
		|| (x >= int'(pong_pkg::DRAW_RIGHT_X_MIN) && in_draw(1, y));
	white = white || (y <= int'(pong_pkg::DRAW_TOP_Y_MAX) && in_draw(2, x))
		|| (y >= int'(pong_pkg::DRAW_BOTTOM_Y_MIN)
		&& y <= int'(pong_pkg::DRAW_BOTTOM_Y_MAX) && in_draw(3, x));
	white = white || m_lives == 0; // game over background
	return white ? pong_pkg::COL_WHITE : pong_pkg::COL_BLACK;
endfunction

// File: tb_pong.sv
module tb_pong;

	localparam int TICK = pong_pkg::TICK_CYCLES;
	localparam int FRAME = pong_pkg::SCREEN_W * pong_pkg::SCREEN_H;
	localparam int LOST_TICKS = 600;  // test lengths in ticks
	localparam int RALLY_TICKS = 1500;
	localparam int OVER_TICKS = 2000;
	localparam int FREEZE_TICKS = 150;
	localparam int RUN_TICKS = 1 + LOST_TICKS + RALLY_TICKS + OVER_TICKS + FREEZE_TICKS
		+ 5 * FRAME / TICK;
	localparam int TIMEOUT_CYCLES = RUN_TICKS * TICK + 2000;

	logic clk = 1'b0;
	logic resetn = 1'b0;
	logic sw_left = 1'b0;
	logic sw_right = 1'b0;
	logic sw_top = 1'b0;
	logic sw_bottom = 1'b0;
	pong_pkg::coord_x_t pix_x;
	pong_pkg::coord_y_t pix_y;
	pong_pkg::colour_t pix_colour;
	pong_pkg::seg_t hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;

	int errors = 0;
	int tests = 0;
	int failed_tests = 0;
	int cyc = -17;        // 0 at the first edge out of reset
	int cycles_run = 0;
	int steer_mode = 0;   // 0 hold, 1 away from ball, 2 onto ball
	bit loss_evt = 1'b0;
	bit score_evt = 1'b0;

	`include "tb_pong_model.svh"

	pong_top i_dut (.*);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycles_run <= cycles_run + 1;
		if (cycles_run >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// clocking, model update and checks
	// ------------------------------------------------------------
	task automatic step_clock();
		@(posedge clk);
		cyc++;
		loss_evt = 1'b0;
		score_evt = 1'b0;
		if (cyc == -1)
			resetn <= 1'b1;
		if (cyc > 0 && cyc % TICK == 0)
			model_tick();    // DUT moves paddles and balls here
		else if (cyc > 1 && cyc % TICK == 1)
			model_score();
		if (cyc >= 0)
			model_scan();
		sw_left <= steer(0);
		sw_right <= steer(1);
		sw_top <= steer(2);
		sw_bottom <= steer(3);
		@(negedge clk);  // outputs settled
	endtask

	task automatic note_failure(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic check_seg(input string name, input pong_pkg::seg_t exp,
		input pong_pkg::seg_t act);
		if (exp !== act)
			note_failure($sformatf("ERROR %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_colour(input string name, input pong_pkg::colour_t exp,
		input pong_pkg::colour_t act);
		if (exp !== act)
			note_failure($sformatf("ERROR %s expected %s actual %s at (%0d,%0d)",
				name, exp.name(), act.name(), scan_x, scan_y));
	endtask

	task automatic check_coord(input string name, input pong_pkg::coord_x_t exp_x,
		input pong_pkg::coord_y_t exp_y, input pong_pkg::coord_x_t act_x,
		input pong_pkg::coord_y_t act_y);
		if (exp_x !== act_x || exp_y !== act_y)
			note_failure($sformatf("ERROR %s expected (%0d,%0d) actual (%0d,%0d)",
				name, exp_x, exp_y, act_x, act_y));
	endtask

	function automatic pong_pkg::seg_t digit_seg(input int d);
		logic [6:0] lit;  // lit segments with bit 0 as a
		case (d)
			1: lit = 7'b0000110;
			2: lit = 7'b1011011;
			3: lit = 7'b1001111;
			4: lit = 7'b1100110;
			5: lit = 7'b1101101;
			6: lit = 7'b1111101;
			7: lit = 7'b0000111;
			8: lit = 7'b1111111;
			9: lit = 7'b1100111;
			default: lit = 7'b0111111;
		endcase
		return ~lit;
	endfunction

	task automatic check_displays(input string name);
		check_seg(name, digit_seg(m_score % 10), hex0);
		check_seg(name, digit_seg(m_score / 10 % 10), hex1);
		check_seg(name, digit_seg(m_score / 100 % 10), hex2);
		check_seg(name, digit_seg(m_score / 1000 % 10), hex3);
		check_seg(name, digit_seg(m_lives % 10), hex4);
		check_seg(name, digit_seg(m_lives / 10), hex5);
		check_seg(name, digit_seg(level2_on() ? 2 : 1), hex6);
		check_seg(name, digit_seg(0), hex7);
	endtask

	task automatic scan_frame(input string name, output int blacks, output int ball1_seen);
		blacks = 0;
		ball1_seen = 0;
		repeat (FRAME)
		begin
			step_clock();
			check_coord(name, pong_pkg::coord_x_t'(scan_x), pong_pkg::coord_y_t'(scan_y),
				pix_x, pix_y);
			check_colour(name, exp_colour(scan_x, scan_y), pix_colour);
			if (pix_colour == pong_pkg::COL_BLACK)
				blacks++;
			if (level2_on() && scan_x == m_bx[1] && scan_y == m_by[1]
				&& pix_colour == pong_pkg::COL_WHITE)
				ball1_seen++;
		end
	endtask

	task automatic report(input string name, input int e0);
		tests++;
		if (errors != e0)
			failed_tests++;
		$display("%s: %s, %0d errors", name, (errors == e0) ? "ok" : "FAILED", errors - e0);
	endtask

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	task automatic test_reset_values();
		int e0;
		e0 = errors;
		repeat (2) step_clock();
		check_displays("reset_values");
		report("reset_values", e0);
	endtask

	task automatic test_frame_scan();
		int e0, blacks, seen;
		e0 = errors;
		scan_frame("frame_scan", blacks, seen);
		report("frame_scan", e0);
	endtask

	task automatic test_ball_lost();
		int e0, n, losses;
		e0 = errors;
		n = 0;
		losses = 0;
		steer_mode = 1;
		while (losses < 3 && n < LOST_TICKS * TICK)
		begin
			step_clock();
			n++;
			if (loss_evt)
			begin
				losses++;
				check_displays("ball_lost");
			end
		end
		if (losses < 3)
			note_failure("ball_lost: the ball was not lost three times in time");
		report("ball_lost", e0);
	endtask

	task automatic test_rally();
		int e0, n, blacks, seen, frames;
		e0 = errors;
		n = 0;
		seen = 0;
		frames = 0;
		steer_mode = 2;
		while (!level2_on() && n < RALLY_TICKS * TICK)
		begin
			step_clock();
			n++;
			if (score_evt)
				check_displays("rally_to_level2");
		end
		if (!level2_on())
			note_failure("rally_to_level2: the score never reached level 2");
		while (seen == 0 && frames < 3)
		begin
			scan_frame("rally_to_level2", blacks, seen);
			frames++;
		end
		if (seen == 0)
			note_failure("rally_to_level2: the second ball never showed on screen");
		report("rally_to_level2", e0);
	endtask

	task automatic test_game_over();
		int e0, n, blacks, seen, hits;
		e0 = errors;
		n = 0;
		hits = 0;
		steer_mode = 0;
		while (m_lives > 0 && n < OVER_TICKS * TICK)
		begin
			step_clock();
			n++;
			if (loss_evt)
				check_displays("game_over");
		end
		if (m_lives > 0)
			note_failure("game_over: lives did not run out in time");
		steer_mode = 2;  // paddles chase the ball so hits arrive with the score frozen
		repeat (FREEZE_TICKS * TICK)
		begin
			step_clock();
			if (score_evt)
			begin
				hits++;
				check_displays("game_over");
			end
		end
		if (hits == 0)
			note_failure("game_over: no paddle hit came while the score was frozen");
		check_displays("game_over");
		scan_frame("game_over", blacks, seen);
		if (blacks != 0)
			note_failure("game_over: the frame still has black pixels");
		report("game_over", e0);
	endtask

	initial
	begin
		repeat (16) step_clock();
		test_reset_values();
		test_frame_scan();
		test_ball_lost();
		test_rally();
		test_game_over();
		$display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: tb_pong_asserts.sv
module pong_asserts (
	input logic clk,
	input logic resetn,
	input pong_pkg::score_t score,
	input pong_pkg::lives_t lives,
	input pong_pkg::coord_x_t pix_x,
	input pong_pkg::coord_y_t pix_y
);

	// one or two hits per edge
	score_steps: assert property (@(posedge clk) disable iff (!resetn)
		score != $past(score) |-> score == $past(score) + 12'd10
		|| score == $past(score) + 12'd20)
		else $error("score moved by an illegal step");

	lives_fall: assert property (@(posedge clk) disable iff (!resetn)
		lives <= $past(lives))
		else $error("lives went up outside reset");

	scan_range: assert property (@(posedge clk) disable iff (!resetn)
		pix_y <= 7'd119 && pix_x <= 8'd159)
		else $error("scan left the screen");

endmodule

bind pong_top pong_asserts u_asserts (.clk(clk), .resetn(resetn), .score(score),
	.lives(lives), .pix_x(pix_x), .pix_y(pix_y));

// File: pong_top.sv
module pong_top (
	input  logic clk,
	input  logic resetn,
	input  logic sw_left,
	input  logic sw_right,
	input  logic sw_top,
	input  logic sw_bottom,
	output pong_pkg::coord_x_t pix_x,
	output pong_pkg::coord_y_t pix_y,
	output pong_pkg::colour_t pix_colour,
	output pong_pkg::seg_t hex0,
	output pong_pkg::seg_t hex1,
	output pong_pkg::seg_t hex2,
	output pong_pkg::seg_t hex3,
	output pong_pkg::seg_t hex4,
	output pong_pkg::seg_t hex5,
	output pong_pkg::seg_t hex6,
	output pong_pkg::seg_t hex7
);

	logic tick;
	pong_pkg::pos_t pad_left, pad_right, pad_top, pad_bottom;
	pong_pkg::pos_t ball0_x, ball0_y, ball1_x, ball1_y;
	logic hit0, hit1, lost0, lost1;
	pong_pkg::score_t score;
	pong_pkg::lives_t lives;
	pong_pkg::level_t level;
	logic level2, game_over;
	pong_pkg::seg_t [3:0] score_seg;
	pong_pkg::seg_t [1:0] lives_seg, level_seg;

	// ------------------------------------------------------------
	// game core
	// ------------------------------------------------------------
	game_tick u_tick (.clk(clk), .resetn(resetn), .tick(tick));

	paddle_ctrl u_paddles (.clk(clk), .resetn(resetn), .tick(tick),
		.sw_left(sw_left), .sw_right(sw_right), .sw_top(sw_top), .sw_bottom(sw_bottom),
		.pad_left(pad_left), .pad_right(pad_right), .pad_top(pad_top),
		.pad_bottom(pad_bottom));

	ball_engine ball0 (.clk(clk), .resetn(resetn), .tick(tick), .active(1'b1),
		.pad_left(pad_left), .pad_right(pad_right), .pad_top(pad_top),
		.pad_bottom(pad_bottom), .ball_x(ball0_x), .ball_y(ball0_y),
		.hit(hit0), .lost(lost0));

	ball_engine ball1 (.clk(clk), .resetn(resetn), .tick(tick), .active(level2), // joins at level 2
		.pad_left(pad_left), .pad_right(pad_right), .pad_top(pad_top),
		.pad_bottom(pad_bottom), .ball_x(ball1_x), .ball_y(ball1_y),
		.hit(hit1), .lost(lost1));

	score_keeper u_score (.clk(clk), .resetn(resetn), .hit0(hit0), .hit1(hit1),
		.lost0(lost0), .lost1(lost1), .score(score), .lives(lives), .level(level),
		.level2(level2), .game_over(game_over));

	frame_render u_render (.clk(clk), .resetn(resetn), .level2(level2),
		.game_over(game_over), .ball0_x(ball0_x), .ball0_y(ball0_y),
		.ball1_x(ball1_x), .ball1_y(ball1_y), .pad_left(pad_left),
		.pad_right(pad_right), .pad_top(pad_top), .pad_bottom(pad_bottom),
		.pix_x(pix_x), .pix_y(pix_y), .pix_colour(pix_colour));

	// displays
	seg_display #(.DIGITS(4)) u_score_seg (.value(score), .seg(score_seg));
	seg_display #(.DIGITS(2)) u_lives_seg (.value({8'd0, lives}), .seg(lives_seg));
	seg_display #(.DIGITS(2)) u_level_seg (.value({8'd0, level}), .seg(level_seg));

	assign hex0 = score_seg[0];
	assign hex1 = score_seg[1];
	assign hex2 = score_seg[2];
	assign hex3 = score_seg[3];
	assign hex4 = lives_seg[0];
	assign hex5 = lives_seg[1];
	assign hex6 = level_seg[0];
	assign hex7 = level_seg[1];

endmodule

// File: seg_display.sv
module seg_display #(
	parameter int DIGITS = 4
) (
	input  pong_pkg::score_t value,
	output pong_pkg::seg_t [DIGITS-1:0] seg
);

	logic [4*DIGITS-1:0] bcd;

	function automatic pong_pkg::seg_t digit_to_seg(input logic [3:0] d);
		case (d)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0011000;
			default: return 7'b1111111; // blank
		endcase
	endfunction

	// shift-add-3, msb of value first
	always_comb
	begin
		bcd = '0;
		for (int i = $bits(value) - 1; i >= 0; i--)
		begin
			for (int d = 0; d < DIGITS; d++)
				if (bcd[4*d +: 4] >= 4'd5)
					bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
			bcd = {bcd[4*DIGITS-2:0], value[i]}; // upper digits drop off for short displays
		end
	end

	always_comb
	begin
		for (int d = 0; d < DIGITS; d++)
			seg[d] = digit_to_seg(bcd[4*d +: 4]); // seg[0] is the ones digit
	end

endmodule

// File: frame_render.sv
module frame_render (
	input  logic clk,
	input  logic resetn,
	input  logic level2,
	input  logic game_over,
	input  pong_pkg::pos_t ball0_x,
	input  pong_pkg::pos_t ball0_y,
	input  pong_pkg::pos_t ball1_x,
	input  pong_pkg::pos_t ball1_y,
	input  pong_pkg::pos_t pad_left,
	input  pong_pkg::pos_t pad_right,
	input  pong_pkg::pos_t pad_top,
	input  pong_pkg::pos_t pad_bottom,
	output pong_pkg::coord_x_t pix_x,
	output pong_pkg::coord_y_t pix_y,
	output pong_pkg::colour_t pix_colour
);

	pong_pkg::pos_t px, py;

	// ------------------------------------------------------------
	// scan, y fastest then x
	// ------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			pix_x <= '0;
			pix_y <= '0;
		end
		else if (pix_y == pong_pkg::coord_y_t'(pong_pkg::SCREEN_H - 1))
		begin
			pix_y <= '0;
			if (pix_x == pong_pkg::coord_x_t'(pong_pkg::SCREEN_W - 1))
				pix_x <= '0;
			else
				pix_x <= pix_x + 1'b1;
		end
		else
			pix_y <= pix_y + 1'b1;
	end

	// scan position in game space
	assign px = pong_pkg::pos_t'({1'b0, pix_x});
	assign py = pong_pkg::pos_t'({2'b00, pix_y});

	always_comb
	begin
		if (px == ball0_x && py == ball0_y)
			pix_colour = pong_pkg::COL_WHITE;
		else if (level2 && px == ball1_x && py == ball1_y)
			pix_colour = pong_pkg::COL_WHITE;
		else if (pad_left < py && py < pad_left + pong_pkg::PADDLE_LEN
			&& pix_x <= pong_pkg::DRAW_LEFT_X_MAX)
			pix_colour = pong_pkg::COL_WHITE;
		else if (pad_right < py && py < pad_right + pong_pkg::PADDLE_LEN
			&& pix_x >= pong_pkg::DRAW_RIGHT_X_MIN && pix_x <= pong_pkg::DRAW_RIGHT_X_MAX)
			pix_colour = pong_pkg::COL_WHITE;
		else if (pad_top < px && px < pad_top + pong_pkg::PADDLE_LEN
			&& pix_y <= pong_pkg::DRAW_TOP_Y_MAX)
			pix_colour = pong_pkg::COL_WHITE;
		else if (pad_bottom < px && px < pad_bottom + pong_pkg::PADDLE_LEN
			&& pix_y >= pong_pkg::DRAW_BOTTOM_Y_MIN && pix_y <= pong_pkg::DRAW_BOTTOM_Y_MAX)
			pix_colour = pong_pkg::COL_WHITE;
		else if (game_over)
			pix_colour = pong_pkg::COL_WHITE; // whole screen goes white
		else
			pix_colour = pong_pkg::COL_BLACK;
	end

endmodule

// File: score_keeper.sv
module score_keeper (
	input  logic clk,
	input  logic resetn,
	input  logic hit0,
	input  logic hit1,
	input  logic lost0,
	input  logic lost1,
	output pong_pkg::score_t score,
	output pong_pkg::lives_t lives,
	output pong_pkg::level_t level,
	output logic level2,
	output logic game_over
);

	pong_pkg::score_t add;
	pong_pkg::lives_t lost_n;

	// both balls may report in the same cycle
	assign add = (hit0 ? pong_pkg::POINTS_PER_HIT : 12'd0)
		+ (hit1 ? pong_pkg::POINTS_PER_HIT : 12'd0);
	assign lost_n = {3'b000, lost0} + {3'b000, lost1};

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			score <= '0;
			lives <= pong_pkg::LIVES_START;
		end
		else
		begin
			if (lives != '0)
				score <= score + add; // frozen once the game is over
			lives <= (lives > lost_n) ? lives - lost_n : '0;
		end
	end

	// ------------------------------------------------------------
	// derived state
	// ------------------------------------------------------------
	assign level2 = (score >= pong_pkg::LEVEL2_SCORE);
	assign level = level2 ? 4'd2 : 4'd1;
	assign game_over = (lives == '0);

endmodule

// File: ball_engine.sv
module ball_engine (
	input  logic clk,
	input  logic resetn,
	input  logic tick,
	input  logic active,
	input  pong_pkg::pos_t pad_left,
	input  pong_pkg::pos_t pad_right,
	input  pong_pkg::pos_t pad_top,
	input  pong_pkg::pos_t pad_bottom,
	output pong_pkg::pos_t ball_x,
	output pong_pkg::pos_t ball_y,
	output logic hit,
	output logic lost
);

	pong_pkg::dir_x_t dir_x, nxt_dir_x;
	pong_pkg::dir_y_t dir_y, nxt_dir_y;
	pong_pkg::pos_t nxt_x, nxt_y;
	logic hit_any, lost_any;

	// ------------------------------------------------------------
	// one game step: move, then bounce and loss tests
	// ------------------------------------------------------------
	always_comb
	begin
		nxt_dir_x = dir_x;
		nxt_dir_y = dir_y;
		hit_any = 1'b0;
		lost_any = 1'b0;
		nxt_x = (dir_x == pong_pkg::DIR_RIGHT) ? ball_x + 9'sd1 : ball_x - 9'sd1;
		nxt_y = (dir_y == pong_pkg::DIR_DOWN) ? ball_y + 9'sd1 : ball_y - 9'sd1;

		if (nxt_x == pong_pkg::HIT_LEFT_X && nxt_y >= pad_left
			&& nxt_y <= pad_left + pong_pkg::PADDLE_LEN)
		begin
			nxt_dir_x = pong_pkg::DIR_RIGHT;
			nxt_x = nxt_x + pong_pkg::BOUNCE_KICK;
			hit_any = 1'b1;
		end
		else if (nxt_x <= pong_pkg::LOST_LEFT_X)
			lost_any = 1'b1;

		if (nxt_x == pong_pkg::HIT_RIGHT_X && nxt_y >= pad_right
			&& nxt_y <= pad_right + pong_pkg::PADDLE_LEN)
		begin
			nxt_dir_x = pong_pkg::DIR_LEFT;
			nxt_x = nxt_x - pong_pkg::BOUNCE_KICK;
			hit_any = 1'b1;
		end
		else if (nxt_x >= pong_pkg::LOST_RIGHT_X)
			lost_any = 1'b1;

		// vertical axis sees the x after any kick above
		if (nxt_y == pong_pkg::HIT_TOP_Y && nxt_x >= pad_top
			&& nxt_x <= pad_top + pong_pkg::PADDLE_LEN)
		begin
			nxt_dir_y = pong_pkg::DIR_DOWN;
			nxt_y = nxt_y + pong_pkg::BOUNCE_KICK;
			hit_any = 1'b1;
		end
		else if (nxt_y <= pong_pkg::LOST_TOP_Y)
			lost_any = 1'b1;

		if (nxt_y == pong_pkg::HIT_BOTTOM_Y && nxt_x >= pad_bottom
			&& nxt_x <= pad_bottom + pong_pkg::PADDLE_LEN)
		begin
			nxt_dir_y = pong_pkg::DIR_UP;
			nxt_y = nxt_y - pong_pkg::BOUNCE_KICK;
			hit_any = 1'b1;
		end
		else if (nxt_y >= pong_pkg::LOST_BOTTOM_Y)
			lost_any = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			ball_x <= pong_pkg::BALL_START_X;
			ball_y <= pong_pkg::BALL_START_Y;
			dir_x <= pong_pkg::DIR_RIGHT;
			dir_y <= pong_pkg::DIR_UP;
			hit <= 1'b0;
			lost <= 1'b0;
		end
		else
		begin
			hit <= 1'b0; // pulses last one cycle
			lost <= 1'b0;
			if (tick && active)
			begin
				dir_x <= nxt_dir_x;
				dir_y <= nxt_dir_y;
				hit <= hit_any;
				lost <= lost_any;
				ball_x <= lost_any ? pong_pkg::BALL_START_X : nxt_x; // respawn at centre
				ball_y <= lost_any ? pong_pkg::BALL_START_Y : nxt_y;
			end
		end
	end

endmodule

// File: paddle_ctrl.sv
module paddle_ctrl (
	input  logic clk,
	input  logic resetn,
	input  logic tick,
	input  logic sw_left,
	input  logic sw_right,
	input  logic sw_top,
	input  logic sw_bottom,
	output pong_pkg::pos_t pad_left,
	output pong_pkg::pos_t pad_right,
	output pong_pkg::pos_t pad_top,
	output pong_pkg::pos_t pad_bottom
);

	// one step of a paddle; dec picks the decreasing direction
	function automatic pong_pkg::pos_t paddle_step(
		input pong_pkg::pos_t pos,
		input logic dec,
		input pong_pkg::pos_t lo,
		input pong_pkg::pos_t hi
	);
		if (dec && pos >= lo)
			return pos - pong_pkg::PADDLE_STEP;
		else if (!dec && pos <= hi)
			return pos + pong_pkg::PADDLE_STEP;
		else
			return pos; // held at the limit
	endfunction

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			pad_left <= pong_pkg::VPADDLE_START;
			pad_right <= pong_pkg::VPADDLE_START;
			pad_top <= pong_pkg::HPADDLE_START;
			pad_bottom <= pong_pkg::HPADDLE_START;
		end
		else if (tick)
		begin
			// side paddles: switch up moves toward the top of the screen
			pad_left <= paddle_step(pad_left, sw_left,
				pong_pkg::VPADDLE_MIN, pong_pkg::VPADDLE_MAX);
			pad_right <= paddle_step(pad_right, sw_right,
				pong_pkg::VPADDLE_MIN, pong_pkg::VPADDLE_MAX);
			// top and bottom run the other way round
			pad_top <= paddle_step(pad_top, !sw_top,
				pong_pkg::HPADDLE_MIN, pong_pkg::HPADDLE_MAX);
			pad_bottom <= paddle_step(pad_bottom, !sw_bottom,
				pong_pkg::HPADDLE_MIN, pong_pkg::HPADDLE_MAX);
		end
	end

endmodule

// File: game_tick.sv
module game_tick (
	input  logic clk,
	input  logic resetn,
	output logic tick
);

	typedef logic [$clog2(pong_pkg::TICK_CYCLES)-1:0] cnt_t;

	cnt_t cnt;

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			cnt <= cnt_t'(pong_pkg::TICK_CYCLES - 1);
			tick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt <= cnt_t'(pong_pkg::TICK_CYCLES - 1); // reload
			tick <= 1'b1;
		end
		else
		begin
			cnt <= cnt - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

// File: pong_pkg.sv
package pong_pkg;

	// ------------------------------------------------------------
	// types
	// ------------------------------------------------------------
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;
	typedef logic signed [8:0] pos_t;   // headroom for overshoot past the edges

	typedef logic [11:0] score_t;
	typedef logic [3:0] lives_t;
	typedef logic [3:0] level_t;
	typedef logic [6:0] seg_t;          // active low, bit 0 is segment a

	typedef enum logic {DIR_LEFT, DIR_RIGHT} dir_x_t;
	typedef enum logic {DIR_UP, DIR_DOWN} dir_y_t;
	typedef enum logic [2:0] {COL_BLACK = 3'b000, COL_WHITE = 3'b111} colour_t;

	// ------------------------------------------------------------
	// screen and play field geometry
	// ------------------------------------------------------------
	localparam int SCREEN_W = 160;
	localparam int SCREEN_H = 120;

	localparam pos_t BALL_START_X = 9'sd80;
	localparam pos_t BALL_START_Y = 9'sd60;

	localparam pos_t PADDLE_LEN = 9'sd25;
	localparam pos_t PADDLE_STEP = 9'sd4;
	localparam pos_t VPADDLE_MIN = 9'sd5;    // left / right
	localparam pos_t VPADDLE_MAX = 9'sd90;
	localparam pos_t VPADDLE_START = 9'sd47;
	localparam pos_t HPADDLE_MIN = 9'sd5;    // top / bottom
	localparam pos_t HPADDLE_MAX = 9'sd133;
	localparam pos_t HPADDLE_START = 9'sd67;

	localparam pos_t HIT_LEFT_X = 9'sd6;
	localparam pos_t HIT_RIGHT_X = 9'sd154;
	localparam pos_t HIT_TOP_Y = 9'sd6;
	localparam pos_t HIT_BOTTOM_Y = 9'sd114;
	localparam pos_t LOST_LEFT_X = 9'sd1;
	localparam pos_t LOST_RIGHT_X = 9'sd158;
	localparam pos_t LOST_TOP_Y = 9'sd1;
	localparam pos_t LOST_BOTTOM_Y = 9'sd119;
	localparam pos_t BOUNCE_KICK = 9'sd2;

	// paddle drawing strips
	localparam coord_x_t DRAW_LEFT_X_MAX = 8'd5;
	localparam coord_x_t DRAW_RIGHT_X_MIN = 8'd155;
	localparam coord_x_t DRAW_RIGHT_X_MAX = 8'd159;
	localparam coord_y_t DRAW_TOP_Y_MAX = 7'd5;
	localparam coord_y_t DRAW_BOTTOM_Y_MIN = 7'd113;
	localparam coord_y_t DRAW_BOTTOM_Y_MAX = 7'd118;

	// ------------------------------------------------------------
	// scoring and pacing
	// ------------------------------------------------------------
	localparam score_t POINTS_PER_HIT = 12'd10;
	localparam lives_t LIVES_START = 4'd15;
	localparam score_t LEVEL2_SCORE = 12'd100;
	localparam int TICK_CYCLES = 64;         // sim rate, raise for a board build

endpackage
